// ==== bench/tb_core.sv ====
// Directed testbench for the control core; drives the Wishbone port and board pins of u2_core_top
`timescale 1ns/1ps

module tb_core import core_pkg::*; ();

   localparam int          RESET_CYCLES = 16;
   localparam int          BUS_WAIT     = 8;        // Cycles allowed for ack or err
   localparam int          MAX_CYCLES   = 2000;     // ~32 accesses of 3 cycles plus waits, wide margin
   localparam logic [31:0] LFSR_SEED    = 32'h0bb725aa;

   logic        wb_clk;
   logic        por_rst;
   wb_addr_t    wb_adr_i;
   wb_data_t    wb_dat_i;
   logic        wb_we_i;
   logic        wb_stb_i;
   logic        wb_cyc_i;
   wb_data_t    wb_dat_o;
   logic        wb_ack_o;
   logic        wb_err_o;
   logic        pps_i;
   logic [3:0]  run_i;
   logic [1:0]  lock_det_i;
   logic        button_i;
   led_t        leds_o;
   logic [1:0]  lms_res_o;
   logic        phy_resetn_o;
   logic        div_sw1_o;
   logic        div_sw2_o;

   logic [31:0] lfsr_q;
   int          cycle_count;

   // Expected register contents
   logic [1:0]  exp_lms;
   logic        exp_phy_rst;
   logic        exp_sw1;
   logic        exp_sw2;
   led_t        exp_led_sw;
   led_t        exp_led_src;

   u2_core_top UUT (.*);

   initial begin
      wb_clk = 1'b0;
      forever #2 wb_clk = ~wb_clk;
   end

   // Run limit
   initial begin
      cycle_count = 0;
      forever begin
         @(posedge wb_clk);
         cycle_count++;
         if (cycle_count >= MAX_CYCLES) begin
            abort_run($sformatf("Timeout: run did not finish within %0d cycles", MAX_CYCLES));
         end
      end
   end

   ////////////////////
   // Reporting and checks

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TEST FAIL");
      $fatal(1, "Stopped at first error");
   endtask

   task automatic check_data(input string name, input wb_data_t got, input wb_data_t exp);
      if (got !== exp) begin
         abort_run($sformatf("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp));
      end
   endtask

   task automatic check_leds(input string name, input led_t got, input led_t exp);
      if (got !== exp) begin
         abort_run($sformatf("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp));
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         abort_run($sformatf("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp));
      end
   endtask

   ////////////////////
   // Stimulus helpers

   // Galois form, taps x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   task automatic rand_word(input int nbits, output wb_data_t val);
      val = '0;
      for (int i = 0; i < nbits; i++) begin
         lfsr_q = lfsr_next(lfsr_q);
         val[i] = lfsr_q[0];
      end
   endtask

   function automatic wb_addr_t set_reg(input int n);
      return wb_addr_t'(32'h7000 + 4 * n);
   endfunction

   function automatic wb_addr_t rb_word(input int n);
      return wb_addr_t'(32'h5C00 + 4 * n);
   endfunction

   // Mask bit 1 takes run line on LEDs 4..1 (zero elsewhere), 0 takes software value
   function automatic led_t led_mix(input led_t src, input led_t sw, input logic [3:0] run);
      led_t hw;
      led_t res;
      hw = '0;
      for (int i = 1; i <= 4; i++) hw[i] = run[i-1];
      for (int i = 0; i < 8; i++) res[i] = src[i] ? hw[i] : sw[i];
      return res;
   endfunction

   task automatic model_reset();
      exp_lms     = 2'b00;
      exp_phy_rst = 1'b0;
      exp_sw1     = 1'b1;
      exp_sw2     = 1'b1;
      exp_led_sw  = 8'h00;
      exp_led_src = 8'h1E;
   endtask

   ////////////////////
   // Bus tasks

   task automatic bus_access(input wb_addr_t adr, input wb_data_t wdata, input logic we,
                             output wb_data_t rdata, output logic err);
      int   waited;
      logic done;
      waited = 0;
      done   = 1'b0;
      @(posedge wb_clk);
      wb_adr_i <= adr;
      wb_dat_i <= wdata;
      wb_we_i  <= we;
      wb_stb_i <= 1'b1;
      wb_cyc_i <= 1'b1;
      while (!done) begin
         @(negedge wb_clk);   // Outputs settled
         if (wb_ack_o || wb_err_o) begin
            done  = 1'b1;
            rdata = wb_dat_o;
            err   = wb_err_o;
         end else begin
            waited++;
            if (waited >= BUS_WAIT) begin
               abort_run($sformatf("No ack or err for access to %h within %0d cycles",
                                   adr, BUS_WAIT));
            end
         end
      end
      @(posedge wb_clk);
      wb_stb_i <= 1'b0;
      wb_cyc_i <= 1'b0;
      wb_we_i  <= 1'b0;
   endtask

   task automatic wb_write(input wb_addr_t adr, input wb_data_t data);
      wb_data_t rdata;
      logic     err;
      bus_access(adr, data, 1'b1, rdata, err);
      check_bit("wb_err_o", err, 1'b0);
   endtask

   task automatic wb_read(input wb_addr_t adr, output wb_data_t data);
      logic err;
      bus_access(adr, '0, 1'b0, data, err);
      check_bit("wb_err_o", err, 1'b0);
   endtask

   task automatic check_outputs();
      @(negedge wb_clk);
      check_bit("wb_ack_o", wb_ack_o, 1'b0);   // Bus is idle here
      check_bit("wb_err_o", wb_err_o, 1'b0);
      check_leds("leds_o", leds_o, led_mix(exp_led_src, exp_led_sw, run_i));
      check_data("lms_res_o", {30'b0, lms_res_o}, {30'b0, exp_lms});
      check_bit("phy_resetn_o", phy_resetn_o, ~exp_phy_rst);
      check_bit("div_sw1_o", div_sw1_o, exp_sw1);
      check_bit("div_sw2_o", div_sw2_o, exp_sw2);
   endtask

   ////////////////////
   // Tests

   task automatic test_reset_values();
      check_outputs();
   endtask

   task automatic test_register_writes();
      wb_data_t v;
      rand_word(32, v);
      wb_write(set_reg(SR_MISC + 0), v);
      exp_lms = v[6:5];
      rand_word(32, v);
      wb_write(set_reg(SR_MISC + 4), v);
      exp_phy_rst = v[0];
      rand_word(32, v);
      wb_write(set_reg(SR_DIVSW + 0), v);
      exp_sw1 = v[0];
      rand_word(32, v);
      wb_write(set_reg(SR_DIVSW + 1), v);
      exp_sw2 = v[0];
      rand_word(32, v);
      wb_write(set_reg(SR_MISC + 3), v);
      exp_led_sw = v[7:0];
      rand_word(32, v);
      wb_write(set_reg(SR_MISC + 6), v);
      exp_led_src = v[7:0];
      rand_word(4, v);
      @(posedge wb_clk);
      run_i <= v[3:0];
      check_outputs();
   endtask

   task automatic test_readback();
      wb_data_t v;
      wb_data_t rd;
      rand_word(3, v);
      @(posedge wb_clk);
      lock_det_i <= v[2:1];
      button_i   <= v[0];
      wb_read(rb_word(12), rd);
      check_data("compat word", rd, 32'h0009_0000);   // Major 9, minor 0
      wb_read(rb_word(13), rd);
      check_data("lock and button word", rd, {16'b0, v[2], v[1], v[0], 13'b0});
      for (int n = 0; n < 10; n++) begin
         wb_read(rb_word(n), rd);
         check_data($sformatf("readback word %0d", n), rd, 32'h0);
      end
   endtask

   task automatic test_unmapped();
      wb_data_t rd;
      logic     err;
      // Bits 9:2 hit the bootloader register if the decoder leaks
      bus_access(16'h1014, 32'h1, 1'b1, rd, err);
      check_bit("wb_err_o on unmapped write", err, 1'b1);
      bus_access(16'h8030, 32'h0, 1'b0, rd, err);
      check_bit("wb_err_o on unmapped read", err, 1'b1);
      repeat (4) @(posedge wb_clk);
      check_outputs();
   endtask

   task automatic test_vita_time();
      wb_data_t hi;
      wb_data_t lo;
      wb_data_t rd;
      rand_word(32, hi);
      rand_word(8, lo);   // Low word near zero
      wb_write(set_reg(SR_TIME64 + 0), hi);
      wb_write(set_reg(SR_TIME64 + 1), lo);
      wb_read(rb_word(10), rd);
      check_data("vita time high", rd, hi);
      wb_read(rb_word(11), rd);
      check_bit("vita time low within 40 of load", (rd >= lo) && (rd - lo < 40), 1'b1);
      @(posedge wb_clk);
      pps_i <= 1'b1;
      repeat (4) @(posedge wb_clk);
      pps_i <= 1'b0;
      repeat (4) @(posedge wb_clk);
      wb_read(rb_word(14), rd);
      check_data("pps time high", rd, hi);
      wb_read(rb_word(15), rd);
      check_bit("pps time low within 80 of load", (rd >= lo) && (rd - lo < 80), 1'b1);
   endtask

   task automatic test_boot_reset();
      wb_data_t v;
      rand_word(32, v);
      wb_write(set_reg(SR_MISC + 3), v);
      exp_led_sw = v[7:0];
      wb_write(set_reg(SR_MISC + 5), 32'h1);
      repeat (6) @(posedge wb_clk);
      model_reset();
      check_outputs();
      // Second boot done must be ignored
      rand_word(32, v);
      wb_write(set_reg(SR_MISC + 0), v);
      exp_lms = v[6:5];
      wb_write(set_reg(SR_DIVSW + 0), 32'h0);
      exp_sw1 = 1'b0;
      wb_write(set_reg(SR_MISC + 4), 32'h1);
      exp_phy_rst = 1'b1;
      wb_write(set_reg(SR_MISC + 5), 32'h1);
      repeat (6) @(posedge wb_clk);
      check_outputs();
   endtask

   ////////////////////
   // Sequence

   initial begin
      wb_data_t v;
      lfsr_q = LFSR_SEED;
      rand_word(4, v);
      por_rst    <= 1'b1;
      wb_adr_i   <= '0;
      wb_dat_i   <= '0;
      wb_we_i    <= 1'b0;
      wb_stb_i   <= 1'b0;
      wb_cyc_i   <= 1'b0;
      pps_i      <= 1'b0;
      run_i      <= v[3:0];
      lock_det_i <= 2'b00;
      button_i   <= 1'b0;
      model_reset();
      repeat (RESET_CYCLES) @(posedge wb_clk);
      por_rst <= 1'b0;
      repeat (2) @(posedge wb_clk);
      test_reset_values();
      test_register_writes();
      test_readback();
      test_unmapped();
      test_vita_time();
      test_boot_reset();
      $display("TEST PASS");
      $finish;
   end

endmodule

// ==== filelist.f ====
logic/core_pkg.sv
logic/wb_slave_if.sv
logic/wb_addr_decoder.sv
logic/settings_bus.sv
logic/control_regs.sv
logic/boot_reset_ctrl.sv
logic/vita_timer.sv
logic/readback_mux.sv
logic/u2_core_top.sv
bench/tb_core.sv

// ==== logic/boot_reset_ctrl.sv ====
// Core reset controller; holds the core in reset at power-up and pulses it once when boot ends
`timescale 1ns/1ps

module boot_reset_ctrl import core_pkg::*; (
   input  logic  wb_clk,
   input  logic  por_rst,
   input  logic  bldr_done_i,
   output logic  core_rst_o
);

   boot_state_t state_q;

   always_ff @(posedge wb_clk) begin
      if (por_rst) begin
         state_q    <= BOOT_WAIT;
         core_rst_o <= 1'b1;
      end else begin
         case (state_q)
            BOOT_WAIT: begin
               core_rst_o <= 1'b0;
               if (bldr_done_i) begin   // Boot code is finished
                  state_q    <= BOOT_DONE;
                  core_rst_o <= 1'b1;   // Clean restart of the core
               end
            end
            BOOT_DONE: begin
               core_rst_o <= 1'b0;      // Stays here until power-on reset
            end
            default: begin
               state_q    <= BOOT_WAIT;
               core_rst_o <= 1'b1;
            end
         endcase
      end
   end

   // After power-up the core reset only rises out of BOOT_WAIT on boot done
   a_no_rst_after_boot: assert property (@(posedge wb_clk) disable iff (por_rst)
      $rose(core_rst_o) |-> $past(state_q == BOOT_WAIT && bldr_done_i));

endmodule

// ==== logic/control_regs.sv ====
// Control settings registers of the core: misc controls, LEDs and diversity switches
`timescale 1ns/1ps

module control_regs import core_pkg::*; (
   input  logic        wb_clk,
   input  logic        core_rst_i,
   input  logic        set_stb_i,
   input  set_addr_t   set_addr_i,
   input  set_data_t   set_data_i,
   input  logic [3:0]  run_i,
   output led_t        leds_o,
   output logic [1:0]  lms_res_o,
   output logic        phy_resetn_o,
   output logic        div_sw1_o,
   output logic        div_sw2_o,
   output logic        bldr_done_o
);

   logic [1:0] lms_res_q;
   logic       phy_rst_q;
   logic       bldr_done_q;
   led_t       led_sw_q;
   led_t       led_src_q;
   logic       div_sw1_q;
   logic       div_sw2_q;
   led_t       led_hw;

   ////////////////////
   // Register file

   always_ff @(posedge wb_clk) begin
      if (core_rst_i) begin
         lms_res_q   <= 2'b00;
         phy_rst_q   <= 1'b0;
         bldr_done_q <= 1'b0;
         led_sw_q    <= '0;
         led_src_q   <= LED_SRC_RESET;
         div_sw1_q   <= 1'b1;
         div_sw2_q   <= 1'b1;
      end else if (set_stb_i) begin
         case (set_addr_i)
            SR_MISC + 8'd0: lms_res_q   <= set_data_i[6:5];   // Clock outputs, LMS reset bits
            SR_MISC + 8'd3: led_sw_q    <= set_data_i[7:0];
            SR_MISC + 8'd4: phy_rst_q   <= set_data_i[0];
            SR_MISC + 8'd5: bldr_done_q <= set_data_i[0];
            SR_MISC + 8'd6: led_src_q   <= set_data_i[7:0];
            SR_DIVSW + 8'd0: div_sw1_q  <= set_data_i[0];
            SR_DIVSW + 8'd1: div_sw2_q  <= set_data_i[0];
            default: ;                                         // Other blocks' registers
         endcase
      end
   end

   assign lms_res_o    = lms_res_q;
   assign phy_resetn_o = ~phy_rst_q;   // PHY reset pin is active low
   assign bldr_done_o  = bldr_done_q;
   assign div_sw1_o    = div_sw1_q;
   assign div_sw2_o    = div_sw2_q;

   ////////////////////
   // LED mix

   // Run lines on LEDs 4..1
   assign led_hw = {3'b000, run_i, 1'b0};

   // Source bit 1 picks hardware, 0 picks software
   assign leds_o = (led_src_q & led_hw) | (~led_src_q & led_sw_q);

endmodule

// ==== logic/core_pkg.sv ====
// Shared types, address map and reset values of the control core, pulled in by wildcard import
package core_pkg;

   ////////////////////
   // Bus and payload types

   typedef logic [15:0] wb_addr_t;    // Wishbone byte address
   typedef logic [31:0] wb_data_t;
   typedef logic [7:0]  set_addr_t;   // Settings register number
   typedef logic [31:0] set_data_t;
   typedef logic [63:0] vita_time_t;
   typedef logic [7:0]  led_t;

   // Bootloader handoff
   typedef enum logic {
      BOOT_WAIT,
      BOOT_DONE
   } boot_state_t;

   ////////////////////
   // Settings register bases

   localparam set_addr_t SR_MISC   = 8'd0;     // 7 regs
   localparam set_addr_t SR_TIME64 = 8'd10;    // Pending high word, then low word
   localparam set_addr_t SR_DIVSW  = 8'd180;   // 2 regs

   ////////////////////
   // Slave windows, matched on address bits 15:8

   localparam logic [7:0] SETTINGS_BASE = 8'h70;
   localparam logic [7:0] SETTINGS_MASK = 8'hF0;   // 4K window
   localparam logic [7:0] READBACK_BASE = 8'h5C;
   localparam logic [7:0] READBACK_MASK = 8'hFC;   // 1K window, 16 words used

   ////////////////////
   // Reset values and identification

   // LEDs 4..1 follow the run lines out of reset
   localparam led_t LED_SRC_RESET = 8'h1E;

   // Bump when the register map changes
   localparam wb_data_t COMPAT_NUM = {16'd9, 16'd0};   // Major, minor

endpackage

// ==== logic/readback_mux.sv ====
// Readback window of the core; sixteen status words read over Wishbone
`timescale 1ns/1ps

module readback_mux import core_pkg::*; (
   input  logic        wb_clk,
   input  logic        core_rst_i,
   wb_slave_if.slave   wb,
   input  vita_time_t  vita_time_i,
   input  vita_time_t  vita_time_pps_i,
   input  logic [1:0]  lock_det_i,
   input  logic        button_i
);

   logic     accept;
   wb_data_t word_sel;
   wb_data_t dat_q;

   assign accept = wb.stb & wb.cyc & ~wb.ack;

   // Word 8 held the router status, now always zero
   always_comb begin
      case (wb.adr[5:2])
         4'd10:   word_sel = vita_time_i[63:32];
         4'd11:   word_sel = vita_time_i[31:0];
         4'd12:   word_sel = COMPAT_NUM;
         4'd13:   word_sel = {16'b0, lock_det_i[1], lock_det_i[0], button_i, 13'b0};
         4'd14:   word_sel = vita_time_pps_i[63:32];
         4'd15:   word_sel = vita_time_pps_i[31:0];
         default: word_sel = '0;
      endcase
   end

   always_ff @(posedge wb_clk) begin
      if (core_rst_i) begin
         wb.ack <= 1'b0;
      end else begin
         wb.ack <= accept;   // Writes are acked and dropped
      end
   end

   always_ff @(posedge wb_clk) begin
      if (accept) begin
         dat_q <= word_sel;
      end
   end

   assign wb.dat_r = dat_q;

endmodule

// ==== logic/settings_bus.sv ====
// Wishbone to settings bus bridge; each write becomes a one-cycle register strobe
`timescale 1ns/1ps

module settings_bus import core_pkg::*; (
   input  logic        wb_clk,
   input  logic        core_rst_i,
   wb_slave_if.slave   wb,
   output logic        set_stb_o,
   output set_addr_t   set_addr_o,
   output set_data_t   set_data_o
);

   logic accept;

   assign accept = wb.stb & wb.cyc & ~wb.ack;   // Held stb is not taken twice

   always_ff @(posedge wb_clk) begin
      if (core_rst_i) begin
         wb.ack    <= 1'b0;
         set_stb_o <= 1'b0;
      end else begin
         wb.ack    <= accept;
         set_stb_o <= accept & wb.we;
      end
   end

   // Word address of the register
   always_ff @(posedge wb_clk) begin
      if (accept) begin
         set_addr_o <= wb.adr[9:2];
         set_data_o <= wb.dat_w;
      end
   end

   assign wb.dat_r = '0;   // Write-only window

   // One ack per access, given while the master still holds its strobe
   a_ack_single: assert property (@(posedge wb_clk) disable iff (core_rst_i)
      wb.ack |=> !wb.ack && $past(wb.stb && wb.cyc));

endmodule

// ==== logic/u2_core_top.sv ====
// Top level of the control core; Wishbone slave port plus board control and status pins
`timescale 1ns/1ps

module u2_core_top import core_pkg::*; (
   input  logic        wb_clk,
   input  logic        por_rst,
   // Wishbone slave
   input  wb_addr_t    wb_adr_i,
   input  wb_data_t    wb_dat_i,
   input  logic        wb_we_i,
   input  logic        wb_stb_i,
   input  logic        wb_cyc_i,
   output wb_data_t    wb_dat_o,
   output logic        wb_ack_o,
   output logic        wb_err_o,
   // Board status
   input  logic        pps_i,
   input  logic [3:0]  run_i,
   input  logic [1:0]  lock_det_i,
   input  logic        button_i,
   // Board control
   output led_t        leds_o,
   output logic [1:0]  lms_res_o,
   output logic        phy_resetn_o,
   output logic        div_sw1_o,
   output logic        div_sw2_o
);

   logic       core_rst;
   logic       bldr_done;
   logic       set_stb;
   set_addr_t  set_addr;
   set_data_t  set_data;
   vita_time_t vita_time;
   vita_time_t vita_time_pps;

   wb_slave_if wb_settings ();
   wb_slave_if wb_readback ();

   ////////////////////
   // Bus

   wb_addr_decoder u_decoder (
      .wb_clk     (wb_clk),    .core_rst_i (core_rst),
      .wb_adr_i   (wb_adr_i),  .wb_dat_i   (wb_dat_i),
      .wb_we_i    (wb_we_i),   .wb_stb_i   (wb_stb_i),
      .wb_cyc_i   (wb_cyc_i),  .wb_dat_o   (wb_dat_o),
      .wb_ack_o   (wb_ack_o),  .wb_err_o   (wb_err_o),
      .settings_o (wb_settings.master),
      .readback_o (wb_readback.master)
   );

   settings_bus u_settings (
      .wb_clk     (wb_clk),    .core_rst_i (core_rst),
      .wb         (wb_settings.slave),
      .set_stb_o  (set_stb),   .set_addr_o (set_addr),  .set_data_o (set_data)
   );

   readback_mux u_readback (
      .wb_clk          (wb_clk),        .core_rst_i (core_rst),
      .wb              (wb_readback.slave),
      .vita_time_i     (vita_time),     .vita_time_pps_i (vita_time_pps),
      .lock_det_i      (lock_det_i),    .button_i        (button_i)
   );

   ////////////////////
   // Control and timing

   boot_reset_ctrl u_boot_rst (
      .wb_clk (wb_clk), .por_rst (por_rst), .bldr_done_i (bldr_done), .core_rst_o (core_rst)
   );

   control_regs u_ctrl (
      .wb_clk       (wb_clk),       .core_rst_i (core_rst),
      .set_stb_i    (set_stb),      .set_addr_i (set_addr),  .set_data_i (set_data),
      .run_i        (run_i),        .leds_o     (leds_o),    .lms_res_o  (lms_res_o),
      .phy_resetn_o (phy_resetn_o), .div_sw1_o  (div_sw1_o), .div_sw2_o  (div_sw2_o),
      .bldr_done_o  (bldr_done)
   );

   vita_timer u_time (
      .wb_clk      (wb_clk),    .core_rst_i (core_rst),
      .set_stb_i   (set_stb),   .set_addr_i (set_addr),  .set_data_i (set_data),
      .pps_i       (pps_i),     .vita_time_o (vita_time),
      .vita_time_pps_o (vita_time_pps)
   );

endmodule

// ==== logic/vita_timer.sv ====
// 64-bit VITA time counter, loaded over the settings bus and sampled on each PPS edge
`timescale 1ns/1ps

module vita_timer import core_pkg::*; (
   input  logic        wb_clk,
   input  logic        core_rst_i,
   input  logic        set_stb_i,
   input  set_addr_t   set_addr_i,
   input  set_data_t   set_data_i,
   input  logic        pps_i,
   output vita_time_t  vita_time_o,
   output vita_time_t  vita_time_pps_o
);

   logic [31:0] time_hi_q;   // Pending high word
   logic        pps_meta;
   logic        pps_sync;
   logic        pps_dly;
   logic        pps_edge;
   logic        wr_hi;
   logic        wr_lo;

   assign wr_hi = set_stb_i && (set_addr_i == SR_TIME64);
   assign wr_lo = set_stb_i && (set_addr_i == SR_TIME64 + 8'd1);

   always_ff @(posedge wb_clk) begin
      if (wr_hi) begin
         time_hi_q <= set_data_i;
      end
   end

   ////////////////////
   // Counter

   always_ff @(posedge wb_clk) begin
      if (core_rst_i) begin
         vita_time_o <= '0;
      end else if (wr_lo) begin
         vita_time_o <= {time_hi_q, set_data_i};   // Low word commits the load
      end else begin
         vita_time_o <= vita_time_o + 64'd1;
      end
   end

   ////////////////////
   // PPS capture

   // pps_i is asynchronous to wb_clk
   always_ff @(posedge wb_clk) begin
      if (core_rst_i) begin
         pps_meta <= 1'b0;
         pps_sync <= 1'b0;
         pps_dly  <= 1'b0;
      end else begin
         pps_meta <= pps_i;
         pps_sync <= pps_meta;
         pps_dly  <= pps_sync;
      end
   end

   assign pps_edge = pps_sync & ~pps_dly;

   always_ff @(posedge wb_clk) begin
      if (core_rst_i) begin
         vita_time_pps_o <= '0;
      end else if (pps_edge) begin
         vita_time_pps_o <= vita_time_o;
      end
   end

endmodule

// ==== logic/wb_addr_decoder.sv ====
// Address decoder for the core bus; routes each access to the settings or readback slave
`timescale 1ns/1ps

module wb_addr_decoder import core_pkg::*; (
   input  logic         wb_clk,
   input  logic         core_rst_i,
   input  wb_addr_t     wb_adr_i,
   input  wb_data_t     wb_dat_i,
   input  logic         wb_we_i,
   input  logic         wb_stb_i,
   input  logic         wb_cyc_i,
   output wb_data_t     wb_dat_o,
   output logic         wb_ack_o,
   output logic         wb_err_o,
   wb_slave_if.master   settings_o,
   wb_slave_if.master   readback_o
);

   logic sel_set;
   logic sel_rb;
   logic err_q;

   ////////////////////
   // Window match

   assign sel_set = ((wb_adr_i[15:8] & SETTINGS_MASK) == SETTINGS_BASE);
   assign sel_rb  = ((wb_adr_i[15:8] & READBACK_MASK) == READBACK_BASE);

   // Address, data and we fan out to both, strobes only to the hit
   assign settings_o.adr   = wb_adr_i;
   assign settings_o.dat_w = wb_dat_i;
   assign settings_o.we    = wb_we_i;
   assign settings_o.cyc   = wb_cyc_i & sel_set;
   assign settings_o.stb   = wb_stb_i & sel_set;

   assign readback_o.adr   = wb_adr_i;
   assign readback_o.dat_w = wb_dat_i;
   assign readback_o.we    = wb_we_i;
   assign readback_o.cyc   = wb_cyc_i & sel_rb;
   assign readback_o.stb   = wb_stb_i & sel_rb;

   ////////////////////
   // Return path

   assign wb_dat_o = sel_rb ? readback_o.dat_r : settings_o.dat_r;
   assign wb_ack_o = settings_o.ack | readback_o.ack;

   // Nobody home, answer with a single err pulse
   always_ff @(posedge wb_clk) begin
      if (core_rst_i) begin
         err_q <= 1'b0;
      end else begin
         err_q <= wb_stb_i & wb_cyc_i & ~sel_set & ~sel_rb & ~err_q;
      end
   end

   assign wb_err_o = err_q;

   // Slave acks and the decoder err must never overlap
   a_ack_err_excl: assert property (@(posedge wb_clk) disable iff (core_rst_i)
      !(wb_ack_o && wb_err_o));

endmodule

// ==== logic/wb_slave_if.sv ====
// One Wishbone slave port between the address decoder and a slave block inside the core
`timescale 1ns/1ps

interface wb_slave_if import core_pkg::*; ();

   wb_addr_t adr;
   wb_data_t dat_w;    // Master to slave
   logic     we;
   logic     stb;
   logic     cyc;
   wb_data_t dat_r;    // Slave to master
   logic     ack;

   // Decoder side
   modport master (
      output adr, dat_w, we, stb, cyc,
      input  dat_r, ack
   );

   // Slave block side
   modport slave (
      input  adr, dat_w, we, stb, cyc,
      output dat_r, ack
   );

endinterface

// ==== run_sim.sh ====
#!/bin/sh
# Build the control core testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f filelist.f --top-module tb_core -o sim_tb_core

# Capture output so the pass line decides the result
output=$(./obj_dir/sim_tb_core 2>&1) || true
echo "$output"

if echo "$output" | grep -qx "TEST PASS"; then
   exit 0
fi
echo "Simulation did not pass"
exit 1
